/* all.f */
common/eth_pkg.sv
common/rmii_pkg.sv
common/byte_stream_if.sv
crc/crc32_d8.sv
rmii_rx/rmii_rx_deser.sv
rmii_rx/rx_fcs_check.sv
rmii_tx/rmii_tx_framer.sv
hdl/eth_rmii_top.sv
test/tb_eth_rmii.sv

/* common/byte_stream_if.sv */
interface byte_stream_if;

    logic       sof;        // First byte after the SFD
    logic       vld;        // One-cycle strobe per byte
    logic [7:0] data;       // Byte value, valid while vld is high
    logic       eof;        // Carrier has dropped, no byte on this cycle

    modport src (
        output sof,
        output vld,
        output data,
        output eof
    );

    modport snk (
        input  sof,
        input  vld,
        input  data,
        input  eof
    );

endinterface

/* common/eth_pkg.sv */
package eth_pkg;

    // CRC register value as seen by the FCS logic
    typedef logic [31:0] crc_t;

    // Frame delimiters sent ahead of the destination address
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    localparam int PREAMBLE_LEN = 7;        // Preamble bytes before the SFD
    localparam int FCS_LEN      = 4;        // Trailer bytes holding the CRC
    localparam int IFG_BYTES    = 12;       // Minimum idle time between frames

    // Reflected form of the IEEE 802.3 polynomial 0x04C11DB7
    localparam crc_t CRC_POLY    = 32'hEDB8_8320;
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;

    // Register contents after a frame followed by its own correct FCS
    localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;

endpackage

/* common/rmii_pkg.sv */
package rmii_pkg;

    // One RMII data transfer, two bits wide on RXD and TXD
    typedef logic [1:0] dibit_t;

    // Bytes move least significant pair first, so bits [1:0] go out first
    localparam int DIBITS_PER_BYTE = 4;

endpackage

/* crc/crc32_d8.sv */
module crc32_d8 (
    input  logic          sys_clk,
    input  logic          sys_rst_n,
    input  logic          start_vld,
    input  logic          data_vld,
    input  logic [7:0]    data,
    output eth_pkg::crc_t crc,
    output eth_pkg::crc_t fcs
);

    eth_pkg::crc_t crc_q;

    // Advance the reflected register over one byte, bit 0 of the byte first.
    // Unrolled by synthesis into the usual eight-level XOR network
    function automatic eth_pkg::crc_t crc_step(
        input eth_pkg::crc_t c,
        input logic [7:0]    d
    );
        eth_pkg::crc_t r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ eth_pkg::CRC_POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            crc_q <= eth_pkg::CRC_INIT;
        end else if (start_vld) begin
            crc_q <= eth_pkg::CRC_INIT;             // Restart wins over a byte update
        end else if (data_vld) begin
            crc_q <= crc_step(crc_q, data);
        end
    end

    // Transmitted FCS is the full 32-bit complement of the register
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            fcs <= '0;
        end else begin
            fcs <= ~crc_q;                          // Lags the register by one cycle
        end
    end

    assign crc = crc_q;

    // Users schedule restart and byte updates on separate cycles
    a_no_start_with_data: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !(start_vld && data_vld)
    );

endmodule

/* hdl/eth_rmii_top.sv */
module eth_rmii_top (
    input  logic                sys_clk,
    input  logic                sys_rst_n,

    // RMII receive pins and user receive side
    input  logic                crs_dv,
    input  rmii_pkg::dibit_t    rxd,
    output logic [7:0]          rx_data,
    output logic                rx_vld,
    output logic                rx_sof,
    output logic                rx_eof,
    output logic                rx_frame_ok,

    // User transmit side and RMII transmit pins
    input  logic                tx_start,
    input  logic [7:0]          tx_data,
    input  logic                tx_last,
    output logic                tx_rd,
    output logic                tx_busy,
    output logic                tx_en,
    output rmii_pkg::dibit_t    txd
);

    byte_stream_if rx_bytes ();     // Deserializer to FCS checker

    rmii_rx_deser rmii_rx_deser_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .crs_dv    (crs_dv),
        .rxd       (rxd),
        .out       (rx_bytes.src)
    );

    rx_fcs_check rx_fcs_check_i (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .in          (rx_bytes.snk),
        .rx_data     (rx_data),
        .rx_vld      (rx_vld),
        .rx_sof      (rx_sof),
        .rx_eof      (rx_eof),
        .rx_frame_ok (rx_frame_ok)
    );

    rmii_tx_framer rmii_tx_framer_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_last   (tx_last),
        .tx_rd     (tx_rd),
        .tx_busy   (tx_busy),
        .tx_en     (tx_en),
        .txd       (txd)
    );

endmodule

/* rmii_rx/rmii_rx_deser.sv */
module rmii_rx_deser (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                crs_dv,
    input  rmii_pkg::dibit_t    rxd,
    byte_stream_if.src          out
);

    logic [7:0] sr;             // Last four dibits, newest in the top pair
    logic [7:0] shifted;        // Shift register including the current dibit
    logic [1:0] cnt;            // Dibit position inside the current byte
    logic       in_frame;       // SFD seen and carrier still present
    logic       first;          // Next byte is the first of the frame
    logic       byte_done;

    assign shifted   = {rxd, sr[7:2]};
    assign byte_done = in_frame && crs_dv && (cnt == 2'(rmii_pkg::DIBITS_PER_BYTE - 1));

    // Cleared while idle so stale bits cannot fake an SFD at carrier rise
    always_ff @(posedge sys_clk) begin
        if (!crs_dv) begin
            sr <= '0;
        end else begin
            sr <= shifted;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            in_frame <= 1'b0;
            cnt      <= '0;
            first    <= 1'b0;
            out.vld  <= 1'b0;
            out.sof  <= 1'b0;
            out.eof  <= 1'b0;
        end else begin
            out.vld <= 1'b0;
            out.sof <= 1'b0;
            out.eof <= 1'b0;
            if (!crs_dv) begin
                out.eof  <= in_frame;                   // Frame closes when carrier drops
                in_frame <= 1'b0;
            end else if (!in_frame) begin
                // Preamble is all 01 pairs, the SFD ends with a 11 pair
                cnt <= '0;
                if (shifted == eth_pkg::SFD_BYTE) begin
                    in_frame <= 1'b1;
                    first    <= 1'b1;
                end
            end else begin
                cnt <= cnt + 2'd1;
                if (byte_done) begin
                    out.vld <= 1'b1;
                    out.sof <= first;
                    first   <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (byte_done) begin
            out.data <= shifted;
        end
    end

    // A byte takes four clocks on the wire, so strobes are always spaced
    a_vld_spaced: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        out.vld |=> !out.vld
    );

endmodule

/* rmii_rx/rx_fcs_check.sv */
module rx_fcs_check (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    byte_stream_if.snk  in,
    output logic [7:0]  rx_data,
    output logic        rx_vld,
    output logic        rx_sof,
    output logic        rx_eof,
    output logic        rx_frame_ok
);

    localparam int FILL_MAX = eth_pkg::FCS_LEN + 1;

    logic [7:0]    dly [eth_pkg::FCS_LEN];      // Index 0 holds the newest byte
    logic [2:0]    fill;                        // Bytes seen this frame, saturates at FILL_MAX
    logic [7:0]    crc_data;
    logic          crc_upd;
    logic          len_ok;                      // Frame held the FCS and one payload byte
    eth_pkg::crc_t crc;

    // Byte updates run one cycle behind so the restart on sof comes first
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            crc_upd <= 1'b0;
        end else begin
            crc_upd <= in.vld;
        end
    end

    always_ff @(posedge sys_clk) begin
        crc_data <= in.data;
    end

    crc32_d8 crc32_d8_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start_vld (in.sof),
        .data_vld  (crc_upd),
        .data      (crc_data),
        .crc       (crc),
        .fcs       ()
    );

    always_ff @(posedge sys_clk) begin
        if (in.vld) begin
            dly[0] <= in.data;
            for (int i = 1; i < eth_pkg::FCS_LEN; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            fill <= '0;
        end else if (in.eof) begin
            fill <= '0;
        end else if (in.vld) begin
            if (in.sof) begin
                fill <= 3'd1;
            end else if (fill != 3'(FILL_MAX)) begin
                fill <= fill + 3'd1;
            end
        end
    end

    // The four newest bytes stay hidden, which leaves the FCS behind at eof
    assign rx_vld  = in.vld && !in.sof && (fill >= 3'(eth_pkg::FCS_LEN));
    assign rx_sof  = rx_vld && (fill == 3'(eth_pkg::FCS_LEN));
    assign rx_data = dly[eth_pkg::FCS_LEN-1];

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_eof <= 1'b0;
            len_ok <= 1'b0;
        end else begin
            rx_eof <= in.eof;
            len_ok <= (fill == 3'(FILL_MAX));           // Needs one payload byte at least
        end
    end

    // The last FCS byte folds into the register on the edge that raises rx_eof
    assign rx_frame_ok = rx_eof && len_ok && (crc == eth_pkg::CRC_RESIDUE);

endmodule

/* rmii_tx/rmii_tx_framer.sv */
module rmii_tx_framer (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                tx_start,
    input  logic [7:0]          tx_data,
    input  logic                tx_last,
    output logic                tx_rd,
    output logic                tx_busy,
    output logic                tx_en,
    output rmii_pkg::dibit_t    txd
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRE,
        ST_SFD,
        ST_DATA,
        ST_FCS,
        ST_GAP
    } state_t;

    state_t        state;
    logic [1:0]    dcnt;        // Dibit position within the byte on the wire
    logic [3:0]    bcnt;        // Byte count for preamble, FCS and gap
    logic [7:0]    sh;          // Byte being sent, shifted right two bits per clock
    logic          last_q;      // Byte in sh was flagged tx_last
    logic          byte_end;
    logic          crc_start;
    logic [1:0]    fcs_sel;
    eth_pkg::crc_t fcs;

    assign byte_end  = (dcnt == 2'(rmii_pkg::DIBITS_PER_BYTE - 1));
    assign tx_rd     = byte_end && ((state == ST_SFD) || (state == ST_DATA && !last_q));
    assign crc_start = (state == ST_SFD) && (dcnt == 2'd0);
    assign fcs_sel   = bcnt[1:0] + 2'd1;
    assign txd       = sh[1:0];

    // Payload bytes fold in as they are latched, fcs is settled well before the trailer
    crc32_d8 crc32_d8_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start_vld (crc_start),
        .data_vld  (tx_rd),
        .data      (tx_data),
        .crc       (),
        .fcs       (fcs)
    );

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state   <= ST_IDLE;
            dcnt    <= '0;
            bcnt    <= '0;
            sh      <= '0;
            last_q  <= 1'b0;
            tx_en   <= 1'b0;
            tx_busy <= 1'b0;
        end else if (state == ST_IDLE) begin
            dcnt <= '0;
            bcnt <= '0;
            if (tx_start) begin
                state   <= ST_PRE;
                tx_en   <= 1'b1;
                tx_busy <= 1'b1;
                sh      <= eth_pkg::PREAMBLE_BYTE;
            end
        end else begin
            dcnt <= dcnt + 2'd1;
            if (!byte_end) begin
                sh <= sh >> 2;
            end else begin
                // Last dibit of a byte is on the wire, pick the next byte
                case (state)
                    ST_PRE: begin
                        if (bcnt == 4'(eth_pkg::PREAMBLE_LEN - 1)) begin
                            state <= ST_SFD;
                            bcnt  <= '0;
                            sh    <= eth_pkg::SFD_BYTE;
                        end else begin
                            bcnt <= bcnt + 4'd1;
                            sh   <= eth_pkg::PREAMBLE_BYTE;
                        end
                    end
                    ST_SFD: begin
                        state  <= ST_DATA;
                        sh     <= tx_data;
                        last_q <= tx_last;
                    end
                    ST_DATA: begin
                        if (last_q) begin
                            state <= ST_FCS;
                            sh    <= fcs[7:0];              // Low byte leads
                        end else begin
                            sh     <= tx_data;
                            last_q <= tx_last;
                        end
                    end
                    ST_FCS: begin
                        if (bcnt == 4'(eth_pkg::FCS_LEN - 1)) begin
                            state <= ST_GAP;
                            bcnt  <= '0;
                            sh    <= '0;
                            tx_en <= 1'b0;
                        end else begin
                            bcnt <= bcnt + 4'd1;
                            sh   <= fcs[{fcs_sel, 3'b000} +: 8];
                        end
                    end
                    ST_GAP: begin
                        if (bcnt == 4'(eth_pkg::IFG_BYTES - 1)) begin
                            state   <= ST_IDLE;
                            tx_busy <= 1'b0;                // Gap is over, accept a new frame
                        end else begin
                            bcnt <= bcnt + 4'd1;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Payload requests only happen inside a frame on the wire
    a_rd_in_frame: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        tx_rd |-> tx_en
    );

endmodule

/* test/tb_eth_rmii.sv */
module tb_eth_rmii;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 4;
    localparam int WATCHDOG_CYCLES = 50 * 1600;        // 50 frames of 1600 cycles each
    localparam int PAY_MAX         = 128;
    localparam int BUF_MAX         = 256;

    logic       sys_clk;
    logic       sys_rst_n;
    logic       crs_dv;
    logic [1:0] rxd;
    logic [7:0] rx_data;
    logic       rx_vld;
    logic       rx_sof;
    logic       rx_eof;
    logic       rx_frame_ok;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_last;
    logic       tx_rd;
    logic       tx_busy;
    logic       tx_en;
    logic [1:0] txd;

    // Receive pins come either from the transmitter or from the direct driver
    logic       loop_sel;
    logic       crs_dv_drv;
    logic [1:0] rxd_drv;

    logic [7:0]  pay [0:PAY_MAX-1];              // Payload of the frame under test
    logic [7:0]  wire_bytes [0:BUF_MAX-1];       // Bytes captured from txd
    logic [7:0]  rx_bytes [0:BUF_MAX-1];
    logic        rx_sofs [0:BUF_MAX-1];
    int          rx_cnt;
    int          eof_cnt;
    logic        rx_ok_last;
    logic [31:0] lcg_state;
    int          errors;
    int          tests_run;
    int          tests_failed;

    assign crs_dv = loop_sel ? tx_en : crs_dv_drv;
    assign rxd    = loop_sel ? txd : rxd_drv;

    eth_rmii_top eth_rmii_top_i (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .crs_dv      (crs_dv),
        .rxd         (rxd),
        .rx_data     (rx_data),
        .rx_vld      (rx_vld),
        .rx_sof      (rx_sof),
        .rx_eof      (rx_eof),
        .rx_frame_ok (rx_frame_ok),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .tx_last     (tx_last),
        .tx_rd       (tx_rd),
        .tx_busy     (tx_busy),
        .tx_en       (tx_en),
        .txd         (txd)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // Records every received byte and the verdict of each frame
    always @(negedge sys_clk) begin
        if (sys_rst_n && rx_vld && rx_cnt < BUF_MAX) begin
            rx_bytes[rx_cnt] = rx_data;
            rx_sofs[rx_cnt]  = rx_sof;
            rx_cnt           = rx_cnt + 1;
        end
        if (sys_rst_n && rx_eof) begin
            rx_ok_last = rx_frame_ok;
            eof_cnt    = eof_cnt + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation ran too long, the watchdog stopped it");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Reflected CRC-32 as in zlib, over pay[0..n-1]
    function automatic logic [31:0] crc32_ref(input int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'h0, pay[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic fill_payload(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r      = lcg_next();
            pay[i] = r[23:16];                  // Upper bits of an LCG are the better ones
        end
    endtask

    task automatic send_tx_frame(input int n);
        int idx;
        int guard;
        guard = 0;
        while (tx_busy && guard < 200) begin
            @(negedge sys_clk);
            guard++;
        end
        if (tx_busy) begin
            $display("Transmitter stayed busy and the frame could not be started");
            errors++;
        end else begin
            tx_data  = pay[0];
            tx_last  = (n == 1);
            tx_start = 1'b1;
            @(negedge sys_clk);
            tx_start = 1'b0;
            idx      = 0;
            guard    = 0;
            while (idx < n && guard < 64 + 8 * n) begin
                if (tx_rd) begin
                    @(negedge sys_clk);         // Byte was latched on the edge in between
                    idx++;
                    if (idx < n) begin
                        tx_data = pay[idx];
                        tx_last = (idx == n - 1);
                    end
                end else begin
                    @(negedge sys_clk);
                end
                guard++;
            end
            if (idx < n) begin
                $display("Transmitter took only %0d of %0d payload bytes", idx, n);
                errors++;
            end
            tx_last = 1'b0;
        end
    endtask

    task automatic capture_tx_wire(output int nbytes, output int gap);
        int         guard;
        int         k;
        logic [7:0] acc;
        guard  = 0;
        nbytes = 0;
        gap    = 0;
        k      = 0;
        acc    = '0;
        while (!tx_en && guard < 100) begin
            @(negedge sys_clk);
            guard++;
        end
        while (tx_en && nbytes < BUF_MAX) begin
            acc = {txd, acc[7:2]};              // First dibit ends up in bits 1:0
            k++;
            if (k == 4) begin
                wire_bytes[nbytes] = acc;
                nbytes++;
                k = 0;
            end
            @(negedge sys_clk);
        end
        if (k != 0) begin
            $display("tx_en fell in the middle of a byte");
            errors++;
        end
        while (tx_busy && gap < 200) begin
            @(negedge sys_clk);
            gap++;
        end
    endtask

    task automatic drive_rx_byte(input logic [7:0] b);
        for (int j = 0; j < 4; j++) begin
            crs_dv_drv = 1'b1;
            rxd_drv    = b[2*j +: 2];
            @(negedge sys_clk);
        end
    endtask

    // Builds preamble, SFD, payload and FCS and drives them on the pins
    task automatic drive_rx_frame(input int pre_len, input int n, input int flip_bit);
        logic [31:0] fcs;
        fcs = crc32_ref(n);
        if (flip_bit >= 0) begin
            pay[flip_bit / 8] = pay[flip_bit / 8] ^ (8'h01 << (flip_bit % 8));
        end
        for (int i = 0; i < pre_len; i++) begin
            drive_rx_byte(8'h55);
        end
        drive_rx_byte(8'hD5);
        for (int i = 0; i < n; i++) begin
            drive_rx_byte(pay[i]);
        end
        for (int i = 0; i < 4; i++) begin
            drive_rx_byte(fcs[8*i +: 8]);
        end
        crs_dv_drv = 1'b0;
        rxd_drv    = 2'b00;
    endtask

    task automatic wait_rx_eof(input int start_cnt);
        int guard;
        guard = 0;
        while (eof_cnt == start_cnt && guard < 3000) begin
            @(negedge sys_clk);
            guard++;
        end
        if (eof_cnt == start_cnt) begin
            $display("Receiver never reported the end of the frame");
            errors++;
        end
    endtask

    task automatic check_rx_frame(input int n, input logic exp_ok);
        if (rx_cnt != n) begin
            $display("[ERROR] %0t: received %0d bytes, expected %0d", $time, rx_cnt, n);
            errors++;
        end
        for (int i = 0; i < n && i < rx_cnt; i++) begin
            if (rx_bytes[i] !== pay[i]) begin
                $display("[ERROR] %0t: rx byte %0d is %h, expected %h",
                         $time, i, rx_bytes[i], pay[i]);
                errors++;
            end
            if (rx_sofs[i] !== (i == 0)) begin
                $display("[ERROR] %0t: rx_sof is %b on byte %0d", $time, rx_sofs[i], i);
                errors++;
            end
        end
        if (rx_ok_last !== exp_ok) begin
            $display("[ERROR] %0t: rx_frame_ok is %b, expected %b", $time, rx_ok_last, exp_ok);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_after_reset();
        int err_before;
        err_before = errors;
        for (int i = 0; i < 20; i++) begin
            @(negedge sys_clk);
            if (tx_en || tx_busy || tx_rd || rx_vld || rx_eof) begin
                $display("[ERROR] %0t: outputs active after reset", $time);
                errors++;
            end
        end
        report_test("after_reset", err_before);
    endtask

    task automatic test_tx_wire();
        int          err_before;
        int          nbytes;
        int          gap;
        logic [31:0] fcs;
        err_before = errors;
        loop_sel   = 1'b0;
        fill_payload(20);
        fcs = crc32_ref(20);
        fork
            send_tx_frame(20);
            capture_tx_wire(nbytes, gap);
        join
        if (nbytes != 32) begin
            $display("[ERROR] %0t: %0d bytes on the wire, expected 32", $time, nbytes);
            errors++;
        end
        for (int i = 0; i < 32 && i < nbytes; i++) begin
            logic [7:0] exp;
            if (i < 7) begin
                exp = 8'h55;
            end else if (i == 7) begin
                exp = 8'hD5;
            end else if (i < 28) begin
                exp = pay[i - 8];
            end else begin
                exp = fcs[8*(i-28) +: 8];       // FCS goes out low byte first
            end
            if (wire_bytes[i] !== exp) begin
                $display("[ERROR] %0t: wire byte %0d is %h, expected %h",
                         $time, i, wire_bytes[i], exp);
                errors++;
            end
        end
        if (gap != 48) begin
            $display("[ERROR] %0t: tx_busy fell %0d cycles after tx_en, expected 48", $time, gap);
            errors++;
        end
        report_test("tx_wire_format", err_before);
    endtask

    task automatic loop_frame(input int n);
        int start_cnt;
        loop_sel  = 1'b1;
        rx_cnt    = 0;
        start_cnt = eof_cnt;
        send_tx_frame(n);
        wait_rx_eof(start_cnt);
        check_rx_frame(n, 1'b1);
    endtask

    task automatic test_loop_good();
        int err_before;
        err_before = errors;
        fill_payload(64);
        loop_frame(64);
        report_test("loopback_good", err_before);
    endtask

    task automatic test_direct(input string name, input int pre_len, input int flip_bit);
        int err_before;
        int start_cnt;
        err_before = errors;
        loop_sel   = 1'b0;
        fill_payload(40);
        rx_cnt    = 0;
        start_cnt = eof_cnt;
        drive_rx_frame(pre_len, 40, flip_bit);
        wait_rx_eof(start_cnt);
        check_rx_frame(40, flip_bit < 0);   // Payload already holds the flipped bit
        report_test(name, err_before);
    endtask

    task automatic test_random_frames();
        int          err_before;
        int          n;
        logic [31:0] r;
        err_before = errors;
        for (int f = 0; f < 10; f++) begin
            r = lcg_next();
            n = (r[23:16] % 100) + 1;
            fill_payload(n);
            loop_frame(n);
        end
        report_test("random_frames", err_before);
    endtask

    initial begin
        sys_clk      = 1'b0;
        sys_rst_n    = 1'b0;
        tx_start     = 1'b0;
        tx_data      = 8'h00;
        tx_last      = 1'b0;
        loop_sel     = 1'b0;
        crs_dv_drv   = 1'b0;
        rxd_drv      = 2'b00;
        rx_cnt       = 0;
        eof_cnt      = 0;
        rx_ok_last   = 1'b0;
        lcg_state    = 32'he475;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(negedge sys_clk);
        sys_rst_n = 1'b1;

        test_after_reset();
        test_tx_wire();
        test_loop_good();
        test_direct("corrupted_frame", 7, 77);
        test_direct("short_preamble", 3, -1);
        test_random_frames();

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
